//--- hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and pc width.
`define CORE_XLEN 32

// register file address width.
`define CORE_REG_AW 5

// program memory size in words.
`define CORE_IMEM_DEPTH 64

// word address width of the program memory.
`define CORE_IMEM_AW 6

// first fetch address out of reset.
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- hw/core_pkg.sv
package core_pkg;

    // command handed from decode to execute.
    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0, // no write, no halt.
        CMD_ADD  = 2'd1, // write src1 + src2 to des.
        CMD_HALT = 2'd2  // stop the core.
    } exu_cmd_t;

    // immediate formats the decoder can build.
    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_I    = 2'd1, // sign-extended inst[31:20].
        IMM_U    = 2'd2  // inst[31:12] in the upper bits.
    } imm_type_t;

endpackage

//--- hw/decode_if.sv
`include "core_defines.svh"

// decoded operands, valid every cycle for the current instruction.
interface decode_if;

    core_pkg::exu_cmd_t      command;
    logic [`CORE_XLEN-1:0]   src1;
    logic [`CORE_XLEN-1:0]   src2;
    logic [`CORE_REG_AW-1:0] des;   // zero when nothing is written.

    modport decode (
        output command,
        output src1,
        output src2,
        output des
    );

    modport execute (
        input command,
        input src1,
        input src2,
        input des
    );

endinterface

//--- hw/fetch_unit.sv
`include "core_defines.svh"

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     halt,
    input  logic                     load_en,
    input  logic [`CORE_IMEM_AW-1:0] load_addr,
    input  logic [`CORE_XLEN-1:0]    load_data,
    output logic [`CORE_XLEN-1:0]    pc,
    output logic [`CORE_XLEN-1:0]    inst
);

    logic [`CORE_XLEN-1:0]    imem [`CORE_IMEM_DEPTH];
    logic [`CORE_IMEM_AW-1:0] word_idx;

    // program load port.
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    assign word_idx = pc[`CORE_IMEM_AW+1:2]; // word aligned fetch.
    assign inst     = imem[word_idx];

    // one instruction per cycle until halt.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_RESET_PC;
        end else if (!halt) begin
            pc <= pc + `CORE_XLEN'd4;
        end
    end

endmodule

//--- hw/decode_unit.sv
`include "core_defines.svh"

module decode_unit (
    input  logic [`CORE_XLEN-1:0]    inst,
    input  logic [`CORE_XLEN-1:0]    pc,
    input  logic [`CORE_XLEN-1:0]    rdata1,
    output logic [`CORE_REG_AW-1:0]  raddr1,
    decode_if.decode                 dec
);

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [2:0] F3_ADDI   = 3'b000;
    localparam logic [2:0] F3_PRIV   = 3'b000;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    reg1_ren;
    logic                    wreg_en;
    core_pkg::imm_type_t     imm_type;
    logic [`CORE_XLEN-1:0]   imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign raddr1  = reg1_ren ? inst[19:15] : '0;
    assign dec.des = wreg_en ? inst[11:7] : '0;

    always_comb begin
        imm_type    = core_pkg::IMM_NONE;
        dec.command = core_pkg::CMD_NOP;
        reg1_ren    = 1'b0;
        wreg_en     = 1'b0;
        case (opcode)
            OP_IMM: begin
                if (funct3 == F3_ADDI) begin // addi.
                    imm_type    = core_pkg::IMM_I;
                    dec.command = core_pkg::CMD_ADD;
                    reg1_ren    = 1'b1;
                    wreg_en     = 1'b1;
                end
            end
            OP_AUIPC: begin // funct3 is part of the immediate.
                imm_type    = core_pkg::IMM_U;
                dec.command = core_pkg::CMD_ADD;
                wreg_en     = 1'b1;
            end
            OP_SYSTEM: begin
                if (funct3 == F3_PRIV) begin // ebreak.
                    dec.command = core_pkg::CMD_HALT;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (imm_type)
            core_pkg::IMM_I: imm = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
            core_pkg::IMM_U: imm = {inst[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    // operand order follows the adder in execute.
    always_comb begin
        case (imm_type)
            core_pkg::IMM_I: begin
                dec.src1 = imm;
                dec.src2 = rdata1;
            end
            core_pkg::IMM_U: begin
                dec.src1 = pc;
                dec.src2 = imm;
            end
            default: begin
                dec.src1 = '0;
                dec.src2 = '0;
            end
        endcase
    end

endmodule

//--- hw/reg_file.sv
`include "core_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CORE_REG_AW-1:0] raddr1,
    output logic [`CORE_XLEN-1:0]   rdata1,
    input  logic                    we,
    input  logic [`CORE_REG_AW-1:0] waddr,
    input  logic [`CORE_XLEN-1:0]   wdata
);

    logic [`CORE_XLEN-1:0] regs [2**`CORE_REG_AW];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**`CORE_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin // x0 is never written.
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

//--- hw/execute_unit.sv
`include "core_defines.svh"

module execute_unit (
    input  logic                    clk,
    input  logic                    reset,
    decode_if.execute               dec,
    output logic                    wb_en,
    output logic [`CORE_REG_AW-1:0] wb_addr,
    output logic [`CORE_XLEN-1:0]   wb_data,
    output logic                    halt
);

    logic is_add;

    assign is_add = (dec.command == core_pkg::CMD_ADD);

    // write-back in the same cycle as the instruction.
    assign wb_en   = is_add && (dec.des != '0) && !halt && !reset;
    assign wb_addr = dec.des;
    assign wb_data = dec.src1 + dec.src2;

    // sticky until reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            halt <= 1'b0;
        end else if (dec.command == core_pkg::CMD_HALT) begin
            halt <= 1'b1;
        end
    end

endmodule

//--- hw/core_top.sv
`include "core_defines.svh"

module core_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_en,
    input  logic [`CORE_IMEM_AW-1:0] load_addr,
    input  logic [`CORE_XLEN-1:0]    load_data,
    output logic [`CORE_XLEN-1:0]    pc,
    output logic                     wb_en,
    output logic [`CORE_REG_AW-1:0]  wb_addr,
    output logic [`CORE_XLEN-1:0]    wb_data,
    output logic                     halt
);

    logic [`CORE_XLEN-1:0]   inst;
    logic [`CORE_REG_AW-1:0] raddr1;
    logic [`CORE_XLEN-1:0]   rdata1;

    decode_if dec_bus ();

    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .halt      (halt),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .inst      (inst)
    );

    decode_unit u_decode (
        .inst   (inst),
        .pc     (pc),
        .rdata1 (rdata1),
        .raddr1 (raddr1),
        .dec    (dec_bus.decode)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .we     (wb_en),   // write-back also drives the ports.
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    execute_unit u_execute (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec_bus.execute),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halt    (halt)
    );

endmodule

//--- sim/core_sva.sv
`include "core_defines.svh"

module core_sva (
    input logic                    clk,
    input logic                    reset,
    input logic [`CORE_XLEN-1:0]   pc,
    input logic [`CORE_XLEN-1:0]   inst,
    input logic                    wb_en,
    input logic [`CORE_REG_AW-1:0] wb_addr,
    input logic                    halt
);

    timeunit 1ns;
    timeprecision 1ps;

    wb_addr_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> ((wb_addr == inst[11:7]) && (wb_addr != '0)))
        else $error("write-back enabled with destination x0 or not rd of the fetched word");

    // sticky halt with a frozen pc.
    halt_frozen: assert property (@(posedge clk) disable iff (reset)
        halt |=> (halt && $stable(pc)))
        else $error("halt dropped or pc moved while halted");

    pc_step: assert property (@(posedge clk) disable iff (reset)
        (!reset && !halt) |=> (pc == $past(pc) + 32'd4))
        else $error("pc did not advance by four while running");

endmodule

//--- sim/core_checker.sv
`include "core_defines.svh"

module core_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_en,
    input  logic [`CORE_IMEM_AW-1:0] load_addr,
    input  logic [`CORE_XLEN-1:0]    load_data,
    input  logic [`CORE_XLEN-1:0]    pc,
    input  logic                     wb_en,
    input  logic [`CORE_REG_AW-1:0]  wb_addr,
    input  logic [`CORE_XLEN-1:0]    wb_data,
    input  logic                     halt,
    output int                       error_count,
    output int                       retired_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [`CORE_XLEN-1:0]                      prog [`CORE_IMEM_DEPTH];
    logic [2**`CORE_REG_AW-1:0][`CORE_XLEN-1:0] model_regs;
    logic [`CORE_XLEN-1:0]                      model_pc;
    logic                                       model_halt;

    function automatic void predict(
        input  logic [`CORE_XLEN-1:0]                      inst,
        input  logic [`CORE_XLEN-1:0]                      cur_pc,
        input  logic [2**`CORE_REG_AW-1:0][`CORE_XLEN-1:0] regs,
        output logic                                       we,
        output logic [`CORE_REG_AW-1:0]                    addr,
        output logic [`CORE_XLEN-1:0]                      data,
        output logic                                       halts
    );
        core_pkg::imm_type_t   kind;
        logic [`CORE_XLEN-1:0] imm_i;
        logic [`CORE_XLEN-1:0] imm_u;
        kind  = core_pkg::IMM_NONE;
        halts = 1'b0;
        imm_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'h000};
        if (inst[6:0] == OPC_OP_IMM && inst[14:12] == 3'b000) begin
            kind = core_pkg::IMM_I;
        end else if (inst[6:0] == OPC_AUIPC) begin
            kind = core_pkg::IMM_U;
        end else if (inst[6:0] == OPC_SYSTEM && inst[14:12] == 3'b000) begin
            halts = 1'b1;
        end
        addr = (kind != core_pkg::IMM_NONE) ? inst[11:7] : '0;
        we   = (kind != core_pkg::IMM_NONE) && (addr != '0);
        case (kind)
            core_pkg::IMM_I: data = imm_i + regs[inst[19:15]]; // model x0 is always zero.
            core_pkg::IMM_U: data = cur_pc + imm_u;
            default:         data = '0;
        endcase
    endfunction

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        error_count++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    initial begin
        error_count   = 0;
        retired_count = 0;
    end

    always @(posedge clk) begin
        logic                    exp_we;
        logic [`CORE_REG_AW-1:0] exp_addr;
        logic [`CORE_XLEN-1:0]   exp_data;
        logic                    exp_halts;
        if (load_en) begin
            prog[load_addr] = load_data; // shadow copy of the program.
        end
        if (reset) begin
            if (wb_en !== 1'b0) report("wb_en", wb_en, 1'b0);
            model_regs = '0;
            model_pc   = `CORE_RESET_PC;
            model_halt = 1'b0;
        end else begin
            if (model_halt) begin
                exp_we    = 1'b0;
                exp_addr  = '0;
                exp_data  = '0;
                exp_halts = 1'b0;
            end else begin
                predict(prog[model_pc[`CORE_IMEM_AW+1:2]], model_pc, model_regs,
                        exp_we, exp_addr, exp_data, exp_halts);
            end
            if (pc !== model_pc) report("pc", pc, model_pc);
            if (halt !== model_halt) report("halt", halt, model_halt);
            if (wb_en !== exp_we) report("wb_en", wb_en, exp_we);
            if (exp_we && wb_addr !== exp_addr) report("wb_addr", wb_addr, exp_addr);
            if (exp_we && wb_data !== exp_data) report("wb_data", wb_data, exp_data);
            if (!model_halt) begin
                retired_count++;
                if (exp_we) begin
                    model_regs[exp_addr] = exp_data;
                end
                model_pc   = model_pc + 32'd4;
                model_halt = exp_halts; // halt shows one cycle after ebreak.
            end
        end
    end

endmodule

//--- sim/core_tb.sv
`include "core_defines.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 8;
    localparam int PROG_WORDS     = 40;
    localparam int MARGIN_CYCLES  = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_WORDS + (PROG_WORDS + 1) + MARGIN_CYCLES;
    localparam int SETTLE_CYCLES  = 5; // time to watch the frozen core.
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                     clk;
    logic                     reset;
    logic                     load_en;
    logic [`CORE_IMEM_AW-1:0] load_addr;
    logic [`CORE_XLEN-1:0]    load_data;
    logic [`CORE_XLEN-1:0]    pc;
    logic                     wb_en;
    logic [`CORE_REG_AW-1:0]  wb_addr;
    logic [`CORE_XLEN-1:0]    wb_data;
    logic                     halt;

    int          cycle_count = 0;
    int          other_errors;
    int          mismatch_count;
    int          retired_count;
    logic [31:0] rng_state;

    core_top UUT (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halt      (halt)
    );

    core_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .pc            (pc),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .halt          (halt),
        .error_count   (mismatch_count),
        .retired_count (retired_count)
    );

    bind core_top core_sva u_sva (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .inst    (inst),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .halt    (halt)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // small register range so results get reused by later instructions.
    function automatic logic [31:0] make_word(input logic [31:0] r);
        logic [4:0] rd;
        logic [4:0] rs1;
        rd  = {2'b00, r[4:2]};
        rs1 = {2'b00, r[7:5]};
        case (r[1:0])
            2'd0, 2'd1: make_word = {r[19:8], rs1, 3'b000, rd, 7'b0010011}; // addi.
            2'd2:       make_word = {r[27:8], rd, 7'b0010111};              // auipc.
            default:    make_word = {r[31:7], 7'b0110011};                  // r-type, unsupported.
        endcase
    endfunction

    task automatic load_program();
        logic [31:0] word;
        for (int i = 0; i < PROG_WORDS; i++) begin
            rng_state = xorshift32(rng_state);
            word      = (i == PROG_WORDS - 1) ? EBREAK : make_word(rng_state);
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[`CORE_IMEM_AW-1:0];
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        other_errors = 0;
        rng_state    = 32'h956a;
        repeat (RESET_CYCLES) @(posedge clk);
        load_program(); // reset stays high while the program goes in.
        reset <= 1'b0;
        while (halt !== 1'b1 && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (halt !== 1'b1) begin
            $display("timed out waiting for halt after %0d cycles", cycle_count);
            other_errors++;
        end else begin
            repeat (SETTLE_CYCLES) @(posedge clk);
        end
        if (retired_count != PROG_WORDS) begin
            $display("checker saw %0d retired instructions instead of %0d",
                     retired_count, PROG_WORDS);
            other_errors++;
        end
        $display("error count: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/core_pkg.sv
hw/decode_if.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/core_top.sv
sim/core_sva.sv
sim/core_checker.sv
sim/core_tb.sv

//--- Bender.yml
package:
  name: rv32_mini_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/decode_if.sv
      - hw/fetch_unit.sv
      - hw/decode_unit.sv
      - hw/reg_file.sv
      - hw/execute_unit.sv
      - hw/core_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/core_sva.sv
      - sim/core_checker.sv
      - sim/core_tb.sv
